//--- common/railEnaIf.sv
// Grouped VR enables
`timescale 1ns/1ns

interface railEnaIf import vrBypassPkg::*; ();

   logic [2:0] bmcEna;      // bit 0 2.5v, bit 1 1.2v, bit 2 1.0v
   logic [2:0] pchEna;      // bit 0 1.8v, bit 1 1.05v, bit 2 vnn
   logic       psEna;       // psu on
   logic       p5vEna;      // 5v main
   logic       auxSwEna;    // 12v aux source select
   logic       sxStbyEna;   // mem 12v from stby
   logic       sxMainEna;   // mem 12v from main
   cpuRailT    cpu0Ena;
   cpuRailT    cpu1Ena;
   memRailT    mem0Ena;
   memRailT    mem1Ena;

   // decoder side
   modport drv (output bmcEna, pchEna, psEna, p5vEna, auxSwEna, sxStbyEna, sxMainEna,
                output cpu0Ena, cpu1Ena, mem0Ena, mem1Ena);

   // top level side, unpacked onto pins
   modport mon (input bmcEna, pchEna, psEna, p5vEna, auxSwEna, sxStbyEna, sxMainEna,
                input cpu0Ena, cpu1Ena, mem0Ena, mem1Ena);

endinterface

//--- common/vrBypassPkg.sv
// VR bypass shared definitions
package vrBypassPkg;

   //////////////////////////////
   // sequence steps
   //////////////////////////////

   localparam int StepW = 5;                     // step code width, one bit per status LED

   // one step per VR enable, order follows the board power-up order
   typedef enum logic [StepW-1:0] {
      INIT                = 5'd0,                // nothing on
      BMC2V5              = 5'd1,
      BMC1V0              = 5'd2,
      BMC1V2              = 5'd3,
      PCH1V8              = 5'd4,
      PCHVNN              = 5'd5,
      PCH1V05             = 5'd6,
      PSUENA              = 5'd7,                // psu on, 12v stby path
      S3_SW               = 5'd8,                // move 12v to main
      P3V3                = 5'd9,
      CPU0_PVPPHBM        = 5'd10,               // cpu0 core group start
      CPU0_PVCCFAEHV      = 5'd11,
      CPU0_PVCCFAEHVFIVRA = 5'd12,
      CPU0_PVCCINFAON     = 5'd13,
      CPU0_PVNN           = 5'd14,
      CPU1_PVPPHBM        = 5'd15,               // cpu1 core group start
      CPU1_PVCCFAEHV      = 5'd16,
      CPU1_PVCCFAEHVFIVRA = 5'd17,
      CPU1_PVCCINFAON     = 5'd18,
      CPU1_PVNN           = 5'd19,
      CPU0_MEM_PVCCDHV    = 5'd20,               // memory rails
      CPU0_MEM_PVCCIN     = 5'd21,
      CPU1_MEM_PVCCDHV    = 5'd22,
      CPU1_MEM_PVCCIN     = 5'd23,
      PLATFORM_ON         = 5'd24                // everything up, hold here
   } stepT;

   //////////////////////////////
   // cpu identification
   //////////////////////////////

   typedef logic [1:0] procIdT;                  // processor id straps
   typedef logic [2:0] pkgIdT;                   // package id straps

   localparam procIdT ProcGnr = 2'd2;            // gnr processor
   localparam pkgIdT  PkgHbm  = 3'd2;            // package with hbm
   localparam pkgIdT  PkgBrd  = 3'd7;            // board default, straps not driven

   //////////////////////////////
   // rail groups
   //////////////////////////////

   // core rails per cpu
   // bit 0 pvpphbm, then pvccfaehv, pvccfaehvfivra, pvccinfaon, pvnn
   localparam int CpuRailN = 5;

   // memory rails per cpu
   // bit 0 pvccdhv, bit 1 pvccin
   localparam int MemRailN = 2;

   typedef logic [CpuRailN-1:0] cpuRailT;
   typedef logic [MemRailN-1:0] memRailT;

endpackage

//--- design/bypassSeq/bypassStepFsm.sv
// Force power-on step counter
`timescale 1ns/1ns

module bypassStepFsm import vrBypassPkg::*; (
   input  logic iClk,
   input  logic iRst_n,
   input  logic iForcePwrOn,        // jumper, high forces the sequence
   output stepT step                // current step, also drives the LEDs
);

   //////////////////////////////
   // step register
   //////////////////////////////

   always_ff @(posedge iClk or negedge iRst_n) begin
      if (!iRst_n) begin
         step <= INIT;
      end else if (!iForcePwrOn) begin
         step <= INIT;              // jumper removed, start over
      end else if (step != PLATFORM_ON) begin
         step <= stepT'(step + StepW'(1));   // one rail per clock
      end
      // at PLATFORM_ON just hold
   end

   //////////////////////////////
   // checks
   //////////////////////////////

   // encodings above PLATFORM_ON are unused
   aStepRange : assert property (
      @(posedge iClk) disable iff (!iRst_n)
      step <= PLATFORM_ON
   ) else $error("bypass step out of range");

   // no skipped rails, the only jump allowed is back to INIT
   aStepMove : assert property (
      @(posedge iClk) disable iff (!iRst_n)
      $changed(step) |-> (step == INIT) || (step == StepW'($past(step) + StepW'(1)))
   ) else $error("bypass step moved by more than one");

endmodule

//--- design/bypassSeq/clkEnaHold.sv
// Sticky clock enables
`timescale 1ns/1ns

module clkEnaHold import vrBypassPkg::*; (
   input  logic iClk,
   input  logic iRst_n,
   input  stepT step,              // current sequence step
   output logic clk25MEna,         // 25 MHz pch clock
   output logic clksDevEna         // device clock generator
);

   logic [1:0] live;               // bit 0 25 MHz, bit 1 device clocks
   logic [1:0] sticky;             // set once, cleared by reset only

   assign live = {step >= P3V3, step >= PSUENA};

   always_ff @(posedge iClk or negedge iRst_n) begin
      if (!iRst_n) begin
         sticky <= '0;
      end else begin
         sticky <= sticky | live;  // jumper drop does not clear these
      end
   end

   // live term makes the enable rise together with its step
   assign clk25MEna  = sticky[0] | live[0];
   assign clksDevEna = sticky[1] | live[1];

   // clocks stay running across a jumper drop
   aClkHold : assert property (
      @(posedge iClk) disable iff (!iRst_n)
      !$fell(clk25MEna) && !$fell(clksDevEna)
   ) else $error("clock enable dropped without reset");

endmodule

//--- design/bypassSeq/railEnaDecoder.sv
// Step to VR enable decoder
`timescale 1ns/1ns

module railEnaDecoder import vrBypassPkg::*; (
   input  stepT      step,          // current sequence step
   railEnaIf.drv     ena            // grouped enables toward the pins
);

   //////////////////////////////
   // enable decode
   //////////////////////////////

   // every enable stays on once its step is reached
   always_comb begin
      // bmc rails
      ena.bmcEna[0] = (step >= BMC2V5);          // 2.5v first
      ena.bmcEna[2] = (step >= BMC1V0);          // 1.0v before 1.2v
      ena.bmcEna[1] = (step >= BMC1V2);

      // pch rails
      ena.pchEna[0] = (step >= PCH1V8);
      ena.pchEna[2] = (step >= PCHVNN);          // vnn ahead of 1.05v
      ena.pchEna[1] = (step >= PCH1V05);

      // psu and 12v switch controls
      ena.psEna     = (step >= PSUENA);
      ena.auxSwEna  = (step >= S3_SW);           // aux 12v moves to main
      ena.sxMainEna = (step >= S3_SW);
      ena.p5vEna    = (step >= P3V3);

      // stby path only while the switch-over runs
      ena.sxStbyEna = (step == PSUENA) || (step == S3_SW);

      // core rails
      // bit i comes up i steps after its group start
      for (int i = 0; i < CpuRailN; i++) begin
         ena.cpu0Ena[i] = (step >= stepT'(CPU0_PVPPHBM + i));
         ena.cpu1Ena[i] = (step >= stepT'(CPU1_PVPPHBM + i));
      end

      // memory rails
      // cpu0 pair first, then cpu1
      for (int i = 0; i < MemRailN; i++) begin
         ena.mem0Ena[i] = (step >= stepT'(CPU0_MEM_PVCCDHV + i));
         ena.mem1Ena[i] = (step >= stepT'(CPU1_MEM_PVCCDHV + i));
      end
   end

endmodule

//--- design/hbmVoltSel.sv
// HBM2/HBM3 supply select
`timescale 1ns/1ns

module hbmVoltSel import vrBypassPkg::*; (
   input  logic   iCpu0SktOcc_n,   // cpu0 socket occupied, active low
   input  logic   iIntrPrsnt,      // interposer fitted
   input  procIdT iCpu0ProcID,
   input  pkgIdT  iCpu0PkgID,
   output logic   hbm2Sel          // 0 hbm3 ~1.8v, 1 hbm2 ~2.5v
);

   logic cpuDirect;                // real cpu0 in the socket
   logic gnrPart;                  // gnr processor id
   logic hbmPkg;                   // hbm package or undriven straps

   // only cpu0 is looked at in bypass mode
   assign cpuDirect = !iCpu0SktOcc_n && !iIntrPrsnt;
   assign gnrPart   = (iCpu0ProcID == ProcGnr);
   assign hbmPkg    = (iCpu0PkgID == PkgHbm) || (iCpu0PkgID == PkgBrd);

   // hbm2 is the safe default
   assign hbm2Sel = !(cpuDirect && gnrPart && hbmPkg);

endmodule

//--- design/vrBypass.sv
// Force power-on VR bypass sequencer
`timescale 1ns/1ns

module vrBypass import vrBypassPkg::*; (
   input  logic             iClk,
   input  logic             iRst_n,
   input  logic             iForcePwrOn,       // force power-on jumper
   input  logic             iCpu0SktOcc_n,     // cpu0 socket occupied, active low
   input  logic             iIntrPrsnt,        // interposer present
   input  procIdT           iCpu0ProcID,
   input  pkgIdT            iCpu0PkgID,

   output logic [StepW-1:0] oLedStatus,        // step number in binary
   output logic             oHbm2Hbm3SelBP,    // 0 selects hbm3

   output logic             oP2v5BmcAuxEnaBP,  // bmc rails
   output logic             oP1v2BmcAuxEnaBP,
   output logic             oP1v0BmcAuxEnaBP,
   output logic             oP1v8PchAuxEnaBP,  // pch rails
   output logic             oP1v05PchAuxEnaBP,
   output logic             oPvnnPchAuxEnaBP,
   output logic             oFmPldClk25MEna,   // 25 MHz clock to pch
   output logic             oFmPldClksDevEna,  // 100 MHz clock generator
   output logic             oPsEnaBP,
   output logic             oP5vEnaBP,
   output logic             oAuxSwEnaBP,       // 12v aux source select
   output logic             oSxSwP12vStbyEnaBP,
   output logic             oSxSwP12vEnaBP,
   output logic             oPvppHbmCpu0EnaBP, // cpu0 core
   output logic             oPvccfaEhvCpu0EnaBP,
   output logic             oPvccfaEhvfivraCpu0EnaBP,
   output logic             oPvccinfaonCpu0EnaBP,
   output logic             oPvnnMainCpu0EnaBP,
   output logic             oPvccdHvCpu0EnaBP, // cpu0 memory
   output logic             oPvccinCpu0EnaBP,
   output logic             oPvppHbmCpu1EnaBP, // cpu1 core
   output logic             oPvccfaEhvCpu1EnaBP,
   output logic             oPvccfaEhvfivraCpu1EnaBP,
   output logic             oPvccinfaonCpu1EnaBP,
   output logic             oPvnnMainCpu1EnaBP,
   output logic             oPvccdHvCpu1EnaBP, // cpu1 memory
   output logic             oPvccinCpu1EnaBP
);

   stepT step;                                 // shared step value

   railEnaIf railEna ();

   //////////////////////////////
   // blocks
   //////////////////////////////

   bypassStepFsm uStepFsm (
      .iClk        (iClk),
      .iRst_n      (iRst_n),
      .iForcePwrOn (iForcePwrOn),
      .step        (step)
   );

   railEnaDecoder uRailDec (
      .step (step),
      .ena  (railEna.drv)
   );

   clkEnaHold uClkHold (
      .iClk       (iClk),
      .iRst_n     (iRst_n),
      .step       (step),
      .clk25MEna  (oFmPldClk25MEna),
      .clksDevEna (oFmPldClksDevEna)
   );

   hbmVoltSel uHbmSel (
      .iCpu0SktOcc_n (iCpu0SktOcc_n),
      .iIntrPrsnt    (iIntrPrsnt),
      .iCpu0ProcID   (iCpu0ProcID),
      .iCpu0PkgID    (iCpu0PkgID),
      .hbm2Sel       (oHbm2Hbm3SelBP)
   );

   //////////////////////////////
   // pin unpacking
   //////////////////////////////

   assign oLedStatus = step;

   assign {oP1v0BmcAuxEnaBP, oP1v2BmcAuxEnaBP, oP2v5BmcAuxEnaBP} = railEna.bmcEna;
   assign {oPvnnPchAuxEnaBP, oP1v05PchAuxEnaBP, oP1v8PchAuxEnaBP} = railEna.pchEna;

   assign oPsEnaBP           = railEna.psEna;
   assign oP5vEnaBP          = railEna.p5vEna;
   assign oAuxSwEnaBP        = railEna.auxSwEna;
   assign oSxSwP12vStbyEnaBP = railEna.sxStbyEna;
   assign oSxSwP12vEnaBP     = railEna.sxMainEna;

   // bit 0 of each rail group is its first rail
   assign {oPvnnMainCpu0EnaBP, oPvccinfaonCpu0EnaBP, oPvccfaEhvfivraCpu0EnaBP,
           oPvccfaEhvCpu0EnaBP, oPvppHbmCpu0EnaBP} = railEna.cpu0Ena;
   assign {oPvnnMainCpu1EnaBP, oPvccinfaonCpu1EnaBP, oPvccfaEhvfivraCpu1EnaBP,
           oPvccfaEhvCpu1EnaBP, oPvppHbmCpu1EnaBP} = railEna.cpu1Ena;

   assign {oPvccinCpu0EnaBP, oPvccdHvCpu0EnaBP} = railEna.mem0Ena;
   assign {oPvccinCpu1EnaBP, oPvccdHvCpu1EnaBP} = railEna.mem1Ena;

endmodule

//--- project.f
common/vrBypassPkg.sv
common/railEnaIf.sv
design/bypassSeq/bypassStepFsm.sv
design/bypassSeq/railEnaDecoder.sv
design/bypassSeq/clkEnaHold.sv
design/hbmVoltSel.sv
design/vrBypass.sv
tests/vrBypassChecker.sv
tests/tbVrBypass.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --assert --top-module tbVrBypass -f project.f -o simv \
   && ./obj_dir/simv | tee /dev/stderr | grep -q "TB PASSED" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- tests/tbVrBypass.sv
// VR bypass sequencer testbench
`timescale 1ns/1ns

module tbVrBypass import vrBypassPkg::*; ();

   localparam int ResetCyc = 16;                 // reset held this many clocks
   localparam int TestN    = 8;

   logic             iClk;
   logic             iRst_n;
   logic             iForcePwrOn;
   logic             iCpu0SktOcc_n;
   logic             iIntrPrsnt;
   procIdT           iCpu0ProcID;
   pkgIdT            iCpu0PkgID;
   logic [StepW-1:0] oLedStatus;
   logic             oHbm2Hbm3SelBP, oFmPldClk25MEna, oFmPldClksDevEna;
   logic             oP2v5BmcAuxEnaBP, oP1v2BmcAuxEnaBP, oP1v0BmcAuxEnaBP;
   logic             oP1v8PchAuxEnaBP, oP1v05PchAuxEnaBP, oPvnnPchAuxEnaBP;
   logic             oPsEnaBP, oP5vEnaBP, oAuxSwEnaBP, oSxSwP12vStbyEnaBP, oSxSwP12vEnaBP;
   logic             oPvppHbmCpu0EnaBP, oPvccfaEhvCpu0EnaBP, oPvccfaEhvfivraCpu0EnaBP;
   logic             oPvccinfaonCpu0EnaBP, oPvnnMainCpu0EnaBP, oPvccdHvCpu0EnaBP, oPvccinCpu0EnaBP;
   logic             oPvppHbmCpu1EnaBP, oPvccfaEhvCpu1EnaBP, oPvccfaEhvfivraCpu1EnaBP;
   logic             oPvccinfaonCpu1EnaBP, oPvnnMainCpu1EnaBP, oPvccdHvCpu1EnaBP, oPvccinCpu1EnaBP;
   int               errCnt;                     // running total from the checker
   int               cycleCnt = 0;
   int               cycleLimit;

   //////////////////////////////
   // stimulus table
   //////////////////////////////

   // ids are {sktOcc_n, intrPrsnt, procId[1:0], pkgId[2:0]}
   string      tName  [TestN] = '{"idle after reset", "full sequence", "drop at platform on",
                                  "partial run with interposer", "drop mid sequence",
                                  "restart with clocks held", "random ids forcing",
                                  "random ids idle"};
   bit         tForce [TestN] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
   int         tHold  [TestN] = '{4, 30, 3, 12, 2, 10, 20, 10};
   logic [6:0] tId    [TestN] = '{7'b1_0_00_111, 7'b0_0_10_010, 7'b0_0_10_111, 7'b0_1_10_010,
                                  7'b0_0_01_010, 7'b1_0_10_010, 7'b0, 7'b0};
   bit         tRnd   [TestN] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

   vrBypass DUT (.*);
   vrBypassChecker uCheck (.*);                  // model and compare

   initial begin
      iClk = 1'b0;
      forever #50 iClk = ~iClk;                  // 100 ns period
   end

   // run limit
   always @(posedge iClk) begin
      cycleCnt++;
      if (cycleCnt > cycleLimit) begin
         $display("timeout: run did not end within %0d cycles", cycleLimit);
         $display("TB FAILED");
         $finish;
      end
   end

   function automatic int totalHold();
      int sum;
      sum = 0;
      foreach (tHold[i]) sum += tHold[i];
      return sum;
   endfunction

   task automatic randomIds();
      iCpu0SktOcc_n = ($urandom % 4) == 0;       // socket mostly occupied
      iIntrPrsnt    = ($urandom % 4) == 0;
      iCpu0ProcID   = procIdT'($urandom);
      iCpu0PkgID    = pkgIdT'($urandom);
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial begin
      int failCnt;
      int rowErr;
      failCnt = 0;
      void'($urandom(32'hcdbb));
      iRst_n        = 1'b0;
      iForcePwrOn   = 1'b0;
      iCpu0SktOcc_n = 1'b1;
      iIntrPrsnt    = 1'b0;
      iCpu0ProcID   = '0;
      iCpu0PkgID    = '0;
      cycleLimit    = totalHold() + ResetCyc + 20;
      repeat (ResetCyc) @(posedge iClk);
      #10;
      iRst_n = 1'b1;
      for (int r = 0; r < TestN; r++) begin
         rowErr = errCnt;
         iForcePwrOn = tForce[r];
         {iCpu0SktOcc_n, iIntrPrsnt, iCpu0ProcID, iCpu0PkgID} = tId[r];
         for (int k = 0; k < tHold[r]; k++) begin
            @(posedge iClk);
            #10;                                 // drive just after the edge
            if (tRnd[r]) randomIds();
         end
         @(negedge iClk);                        // last result of the row checked here
         #1;
         rowErr = errCnt - rowErr;
         if (rowErr != 0) failCnt++;
         $display("test %0d %s: %s, %0d errors", r, tName[r], rowErr ? "fail" : "ok", rowErr);
         @(posedge iClk);
         #10;
      end
      $display("tests %0d, failed %0d, errors %0d", TestN, failCnt, errCnt);
      if (failCnt == 0 && errCnt == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

//--- tests/vrBypassChecker.sv
// VR bypass reference checker
`timescale 1ns/1ns

module vrBypassChecker import vrBypassPkg::*; (
   input  logic             iClk, iRst_n, iForcePwrOn, iCpu0SktOcc_n, iIntrPrsnt,
   input  procIdT           iCpu0ProcID,
   input  pkgIdT            iCpu0PkgID,
   input  logic [StepW-1:0] oLedStatus,
   input  logic             oHbm2Hbm3SelBP, oFmPldClk25MEna, oFmPldClksDevEna,
   input  logic             oP2v5BmcAuxEnaBP, oP1v0BmcAuxEnaBP, oP1v2BmcAuxEnaBP,
   input  logic             oP1v8PchAuxEnaBP, oPvnnPchAuxEnaBP, oP1v05PchAuxEnaBP,
   input  logic             oPsEnaBP, oAuxSwEnaBP, oSxSwP12vEnaBP, oP5vEnaBP, oSxSwP12vStbyEnaBP,
   input  logic             oPvppHbmCpu0EnaBP, oPvccfaEhvCpu0EnaBP, oPvccfaEhvfivraCpu0EnaBP,
   input  logic             oPvccinfaonCpu0EnaBP, oPvnnMainCpu0EnaBP,
   input  logic             oPvppHbmCpu1EnaBP, oPvccfaEhvCpu1EnaBP, oPvccfaEhvfivraCpu1EnaBP,
   input  logic             oPvccinfaonCpu1EnaBP, oPvnnMainCpu1EnaBP,
   input  logic             oPvccdHvCpu0EnaBP, oPvccinCpu0EnaBP,
   input  logic             oPvccdHvCpu1EnaBP, oPvccinCpu1EnaBP,
   output int               errCnt
);

   int mStep    = 0;                             // model step, 0 INIT to 24 PLATFORM_ON
   bit seen25   = 1'b0;                          // 25 MHz clock ever enabled
   bit seenDev  = 1'b0;
   int errTotal = 0;

   // step at which each rail bit turns on, index matches railName
   int    onStep   [24] = '{1, 2, 3, 4, 5, 6, 7, 8, 8, 9, 10, 11, 12, 13, 14, 15, 16, 17, 18, 19,
                            20, 21, 22, 23};
   string railName [25] = '{"oP2v5BmcAuxEnaBP", "oP1v0BmcAuxEnaBP", "oP1v2BmcAuxEnaBP",
      "oP1v8PchAuxEnaBP", "oPvnnPchAuxEnaBP", "oP1v05PchAuxEnaBP", "oPsEnaBP", "oAuxSwEnaBP",
      "oSxSwP12vEnaBP", "oP5vEnaBP", "oPvppHbmCpu0EnaBP", "oPvccfaEhvCpu0EnaBP",
      "oPvccfaEhvfivraCpu0EnaBP", "oPvccinfaonCpu0EnaBP", "oPvnnMainCpu0EnaBP",
      "oPvppHbmCpu1EnaBP", "oPvccfaEhvCpu1EnaBP", "oPvccfaEhvfivraCpu1EnaBP",
      "oPvccinfaonCpu1EnaBP", "oPvnnMainCpu1EnaBP", "oPvccdHvCpu0EnaBP", "oPvccinCpu0EnaBP",
      "oPvccdHvCpu1EnaBP", "oPvccinCpu1EnaBP", "oSxSwP12vStbyEnaBP"};

   assign errCnt = errTotal;

   task automatic reportMismatch(string sig, logic [31:0] got, logic [31:0] want);
      $display("ERROR %s got 0x%0h expected 0x%0h at %0t", sig, got, want, $time);
      errTotal++;
   endtask

   // step model, one step per edge while the jumper is in
   always @(posedge iClk or negedge iRst_n) begin
      if (!iRst_n)
         mStep <= 0;
      else if (!iForcePwrOn)
         mStep <= 0;
      else if (mStep < 24)
         mStep <= mStep + 1;
   end

   //////////////////////////////
   // compare, mid cycle
   //////////////////////////////

   always @(negedge iClk) begin : checkEdge
      logic [24:0] gotRail;
      logic [24:0] wantRail;
      logic        wantHbm;
      if (!iRst_n) begin
         seen25  = 1'b0;                         // only reset clears the clocks
         seenDev = 1'b0;
      end else begin
         seen25  = seen25 | (mStep >= 7);        // PSUENA
         seenDev = seenDev | (mStep >= 9);       // P3V3
      end
      gotRail = {oSxSwP12vStbyEnaBP, oPvccinCpu1EnaBP, oPvccdHvCpu1EnaBP, oPvccinCpu0EnaBP,
                 oPvccdHvCpu0EnaBP, oPvnnMainCpu1EnaBP, oPvccinfaonCpu1EnaBP,
                 oPvccfaEhvfivraCpu1EnaBP, oPvccfaEhvCpu1EnaBP, oPvppHbmCpu1EnaBP,
                 oPvnnMainCpu0EnaBP, oPvccinfaonCpu0EnaBP, oPvccfaEhvfivraCpu0EnaBP,
                 oPvccfaEhvCpu0EnaBP, oPvppHbmCpu0EnaBP, oP5vEnaBP, oSxSwP12vEnaBP,
                 oAuxSwEnaBP, oPsEnaBP, oP1v05PchAuxEnaBP, oPvnnPchAuxEnaBP, oP1v8PchAuxEnaBP,
                 oP1v2BmcAuxEnaBP, oP1v0BmcAuxEnaBP, oP2v5BmcAuxEnaBP};
      for (int i = 0; i < 24; i++)
         wantRail[i] = (mStep >= onStep[i]);
      wantRail[24] = (mStep == 7) || (mStep == 8);   // stby switch window only
      // hbm3 needs cpu0 direct in socket, gnr id 2, package 2 or 7
      wantHbm = !(!iCpu0SktOcc_n && !iIntrPrsnt && iCpu0ProcID == 2'd2 &&
                  (iCpu0PkgID == 3'd2 || iCpu0PkgID == 3'd7));
      for (int i = 0; i < 25; i++) begin
         if (gotRail[i] !== wantRail[i])
            reportMismatch(railName[i], 32'(gotRail[i]), 32'(wantRail[i]));
      end
      if (oLedStatus !== StepW'(mStep))
         reportMismatch("oLedStatus", 32'(oLedStatus), 32'(mStep));
      if (oHbm2Hbm3SelBP !== wantHbm)
         reportMismatch("oHbm2Hbm3SelBP", 32'(oHbm2Hbm3SelBP), 32'(wantHbm));
      if (oFmPldClk25MEna !== seen25)
         reportMismatch("oFmPldClk25MEna", 32'(oFmPldClk25MEna), 32'(seen25));
      if (oFmPldClksDevEna !== seenDev)
         reportMismatch("oFmPldClksDevEna", 32'(oFmPldClksDevEna), 32'(seenDev));
   end

endmodule
